//--- Bender.yml
package:
  name: bgfetch

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/bgfetch_pkg.sv
      - verilog/bgfetchUcodeRom.sv
      - verilog/bgfetchSequencer.sv
      - verilog/tileRowFifo.sv
      - verilog/pixelSerializer.sv
      - verilog/bgfetchTop.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/bgfetch_chk.sv
      - bench/bgfetchTb.sv

//--- bench/bgfetchTb.sv
`timescale 1ns/10ps
`include "bgfetch_params.svh"

module bgfetchTb;
    import bgfetch_pkg::*;

    localparam int PixelsPerLine = `BGF_TILES_PER_LINE * 8;
    localparam int LineTimeout = 6000;

    logic        clock;
    logic        reset;
    logic        start;
    logic [7:0]  line;
    logic [4:0]  scrollTile;
    wbReq_t      wbReq;
    logic [7:0]  wbDat;
    logic        wbAck;
    logic [1:0]  pixel;
    logic        pixelValid;
    logic        pixelReady;
    logic        busy;
    logic        done;

    // Whole 8 KB of video memory behind the Wishbone slave model
    logic [7:0]  vram [1 << `BGF_ADDR_W];
    logic [31:0] lfsr = 32'hb84f_345a;

    bit          ackRandom = 0;
    bit          readyRandom = 0;
    int          ackWait = 0;
    logic        pixTaken;
    logic [1:0]  pixNow;
    logic        doneSeen;
    bit          timedOut = 0;
    int          errorCount = 0;
    int          testsRun = 0;
    int          testsFailed = 0;

    bgfetchTop UUT
    (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .line       (line),
        .scrollTile (scrollTile),
        .wbReq      (wbReq),
        .wbDat      (wbDat),
        .wbAck      (wbAck),
        .pixel      (pixel),
        .pixelValid (pixelValid),
        .pixelReady (pixelReady),
        .busy       (busy),
        .done       (done)
    );

    initial
    begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    //////////////////////////////////////////////////////////////////////
    // Random source and reference model
    //////////////////////////////////////////////////////////////////////

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit
    function automatic logic lfsrStep();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
            r = {r[30:0], lfsrStep()};
        return r;
    endfunction

    // Pixel idx of the line, counted from the left screen edge
    function automatic logic [1:0] expectedPixel(logic [7:0] ln, logic [4:0] sc, int idx);
        int                   col;
        int                   bitPos;
        logic [`BGF_ADDR_W-1:0] mapAdr;
        logic [`BGF_ADDR_W-1:0] tileAdr;
        logic [7:0]           tileIdx;
        logic [7:0]           lo;
        logic [7:0]           hi;
        col = idx / 8;
        bitPos = 7 - (idx % 8);
        // The map column wraps at 32 tiles
        mapAdr = `BGF_ADDR_W'(`BGF_MAP_BASE + (ln / 8) * 32 + ((sc + col) % 32));
        tileIdx = vram[mapAdr];
        tileAdr = `BGF_ADDR_W'(`BGF_TILE_BASE + tileIdx * 16 + (ln % 8) * 2);
        lo = vram[tileAdr];
        hi = vram[`BGF_ADDR_W'(tileAdr + 1)];
        return {hi[bitPos], lo[bitPos]};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Per-cycle bus models
    //////////////////////////////////////////////////////////////////////

    // Advances one clock, answers the VRAM bus and drives pixelReady
    task automatic stepCycle();
        @(posedge clock);
        #2;
        if (wbAck)
        begin
            // The master took the data at this edge
            wbAck = 1'b0;
            ackWait = ackRandom ? int'(randBits(2)) : 0;
        end
        else if (wbReq.cyc && wbReq.stb)
        begin
            if (ackWait == 0)
            begin
                wbAck = 1'b1;
                wbDat = vram[wbReq.adr];
            end
            else
                ackWait--;
        end
        // Ready one cycle in four drains slower than the fetch, so the FIFO fills
        pixelReady = readyRandom ? (randBits(2) == 0) : 1'b1;
        // Whatever is offered now transfers at the coming edge
        pixTaken = pixelValid && pixelReady;
        pixNow = pixel;
        doneSeen = done;
    endtask

    task automatic checkLow(input string name, input logic value, inout int errs);
        assert (value === 1'b0)
        else
        begin
            $display("ERR %s: expected 0x0, got 0x%h", name, value);
            errs++;
        end
    endtask

    task automatic reportTest(input int num, input string name, input int errs);
        testsRun++;
        errorCount += errs;
        if (errs == 0 && !timedOut)
            $display("[%0d] %s: ok", num, name);
        else
        begin
            testsFailed++;
            $display("[%0d] %s: FAIL with %0d errors", num, name, errs);
        end
    endtask

    // One full scanline, runs until all pixels and done are seen and the unit idles
    task automatic runLine(input logic [7:0] ln, input logic [4:0] sc, input bit randAck,
                           input bit randReady, input bit startAgain, inout int errs);
        int         pixCount;
        int         doneCount;
        int         cycles;
        int         quiet;
        logic [1:0] expPix;
        if (timedOut)
            return;
        ackRandom = randAck;
        readyRandom = randReady;
        pixCount = 0;
        doneCount = 0;
        cycles = 0;
        quiet = 0;
        start = 1'b1;
        line = ln;
        scrollTile = sc;
        while (quiet < 20 && !timedOut)
        begin
            stepCycle();
            cycles++;
            start = startAgain && (cycles == 30);
            // A second start carries other values which must not be latched
            if (startAgain && cycles == 30)
            begin
                line = ~ln;
                scrollTile = sc + 5'd7;
            end
            if (pixTaken)
            begin
                if (pixCount < PixelsPerLine)
                begin
                    expPix = expectedPixel(ln, sc, pixCount);
                    assert (pixNow == expPix)
                    else
                    begin
                        $display("ERR pixel[%0d]: expected 0x%h, got 0x%h",
                                 pixCount, expPix, pixNow);
                        errs++;
                    end
                end
                pixCount++;
            end
            if (doneSeen)
                doneCount++;
            // Quiet cycles after the line catch late duplicates
            if (doneCount > 0 && pixCount >= PixelsPerLine && !pixelValid && !busy)
                quiet++;
            else
                quiet = 0;
            if (cycles > LineTimeout)
                timedOut = 1;
        end
        if (timedOut)
        begin
            $display("timeout: line %0d did not finish, %0d pixels and %0d done pulses seen",
                     ln, pixCount, doneCount);
            errs++;
        end
        else
        begin
            assert (pixCount == PixelsPerLine)
            else
            begin
                $display("line %0d delivered %0d pixels instead of %0d",
                         ln, pixCount, PixelsPerLine);
                errs++;
            end
            assert (doneCount == 1)
            else
            begin
                $display("done pulsed %0d times for line %0d instead of once", doneCount, ln);
                errs++;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        int         errs;
        int         chkFails;
        logic [7:0] ln;
        logic [4:0] sc;
        reset = 1'b1;
        start = 1'b0;
        line = '0;
        scrollTile = '0;
        wbDat = '0;
        wbAck = 1'b0;
        pixelReady = 1'b0;
        for (int a = 0; a < (1 << `BGF_ADDR_W); a++)
            vram[a] = 8'(randBits(8));
        repeat (16) @(posedge clock);
        #2;
        reset = 1'b0;

        // Nothing may move without a start
        errs = 0;
        repeat (50)
        begin
            stepCycle();
            checkLow("cyc", wbReq.cyc, errs);
            checkLow("pixelValid", pixelValid, errs);
            checkLow("busy", busy, errs);
            checkLow("done", done, errs);
        end
        reportTest(1, "idle after reset", errs);

        errs = 0;
        ln = 8'(randBits(8));
        sc = 5'(randBits(5));
        runLine(ln, sc, 0, 0, 0, errs);
        reportTest(2, "single line, fast ack, ready held", errs);

        errs = 0;
        repeat (3)
        begin
            ln = 8'(randBits(8));
            sc = 5'(randBits(5));
            runLine(ln, sc, 1, 0, 0, errs);
        end
        reportTest(3, "random ack delays", errs);

        errs = 0;
        repeat (3)
        begin
            ln = 8'(randBits(8));
            sc = 5'(randBits(5));
            runLine(ln, sc, 1, 1, 0, errs);
        end
        reportTest(4, "random pixelReady back-pressure", errs);

        // Columns 25 to 31 then 0 to 12
        errs = 0;
        ln = 8'(randBits(8));
        runLine(ln, 5'd25, 0, 0, 0, errs);
        reportTest(5, "map column wrap", errs);

        errs = 0;
        ln = 8'(randBits(8));
        sc = 5'(randBits(5));
        runLine(ln, sc, 1, 0, 1, errs);
        reportTest(6, "start while busy ignored", errs);

        chkFails = UUT.sequencer.seqChk.failCount + UUT.serializer.serChk.failCount;
        $display("%0d tests, %0d failing, %0d check errors, %0d assertion failures",
                 testsRun, testsFailed, errorCount, chkFails);
        if (testsFailed == 0 && errorCount == 0 && chkFails == 0 && !timedOut)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

//--- bench/bgfetch_chk.sv
`timescale 1ns/10ps
`include "bgfetch_params.svh"

module bgfetchChk
(
    input logic                   clock,
    input logic                   reset,
    input logic                   cyc,
    input logic                   stb,
    input logic [`BGF_ADDR_W-1:0] adr,
    input logic                   ack,
    input logic                   pushReq,
    input logic                   full,
    input logic [1:0]             pixel,
    input logic                   pixelValid,
    input logic                   pixelReady
);

    // Read back by the testbench once the run is over
    int failCount = 0;

    //////////////////////////////////////////////////////////////////////
    // Wishbone classic master side
    //////////////////////////////////////////////////////////////////////

    strobeInCycle: assert property (@(posedge clock) disable iff (reset) stb |-> cyc)
    else
    begin
        $error("stb is high without cyc");
        failCount++;
    end

    // A request keeps its strobe and address until the slave acks
    requestHeld: assert property (@(posedge clock) disable iff (reset)
        cyc && stb && !ack |=> stb && $stable(adr))
    else
    begin
        $error("Wishbone request changed before ack");
        failCount++;
    end

    // A block that meets a full FIFO stays pending until room appears
    pushHeldWhileFull: assert property (@(posedge clock) disable iff (reset)
        pushReq && full |=> pushReq)
    else
    begin
        $error("pending push abandoned while the FIFO was full");
        failCount++;
    end

    //////////////////////////////////////////////////////////////////////
    // Pixel stream side
    //////////////////////////////////////////////////////////////////////

    // A stalled pixel must be offered again unchanged
    pixelHeld: assert property (@(posedge clock) disable iff (reset)
        pixelValid && !pixelReady |=> pixelValid && $stable(pixel))
    else
    begin
        $error("pixel changed or dropped while stalled");
        failCount++;
    end

endmodule

// The sequencer instance watches only the bus and push side
bind bgfetchSequencer bgfetchChk seqChk
(
    .clock (clock), .reset (reset),
    .cyc (wbReq.cyc), .stb (wbReq.stb), .adr (wbReq.adr), .ack (wbAck),
    .pushReq (busy && (uop.op == bgfetch_pkg::uopPushBlock)), .full (full),
    .pixel (2'b00), .pixelValid (1'b0), .pixelReady (1'b0)
);

// The serializer instance watches only the pixel handshake
bind pixelSerializer bgfetchChk serChk
(
    .clock (clock), .reset (reset),
    .cyc (1'b0), .stb (1'b0), .adr ('0), .ack (1'b0),
    .pushReq (1'b0), .full (1'b0),
    .pixel (pixel), .pixelValid (pixelValid), .pixelReady (pixelReady)
);

//--- sim.f
+incdir+verilog
verilog/bgfetch_pkg.sv
verilog/bgfetchUcodeRom.sv
verilog/bgfetchSequencer.sv
verilog/tileRowFifo.sv
verilog/pixelSerializer.sv
verilog/bgfetchTop.sv
bench/bgfetch_chk.sv
bench/bgfetchTb.sv

//--- verilog/bgfetchSequencer.sv
`timescale 1ns/10ps
`include "bgfetch_params.svh"

module bgfetchSequencer
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   start,
    input  logic [7:0]             line,
    input  logic [4:0]             scrollTile,
    output bgfetch_pkg::wbReq_t    wbReq,
    input  logic [7:0]             wbDat,
    input  logic                   wbAck,
    output logic                   push,
    output bgfetch_pkg::pixBlock_t block,
    input  logic                   full,
    output logic                   busy,
    output logic                   done
);
    import bgfetch_pkg::*;

    localparam int AddrW = `BGF_ADDR_W;
    localparam int NumRegs = 11;

    // Wait covers both an outstanding VRAM read and a push into a full FIFO
    typedef enum logic [1:0] { seqIdle, seqRun, seqWait } seqState_t;

    seqState_t        state;
    logic [4:0]       uPc;
    ucode_t           uop;
    logic [AddrW-1:0] regFile [NumRegs];
    logic [AddrW-1:0] aVal;
    logic [AddrW-1:0] bVal;
    logic [AddrW-1:0] aluOut;
    logic [AddrW-1:0] wrData;
    logic [7:0]       imm;
    logic             wrEn;

    bgfetchUcodeRom ucodeRom
    (
        .uPc (uPc),
        .uop (uop)
    );

    //////////////////////////////////////////////////////////////////////
    // Operand fetch and ALU
    //////////////////////////////////////////////////////////////////////

    assign aVal = (uop.srcA == regNull) ? '0 : regFile[uop.srcA];
    assign bVal = (uop.arg.b.srcB == regNull) ? '0 : regFile[uop.arg.b.srcB];
    assign imm = uop.arg.i.imm;

    always_comb
    begin
        aluOut = '0;
        wrEn = 1'b0;
        case (uop.op)
            uopLoadImm:
            begin
                aluOut = AddrW'(imm);
                wrEn = 1'b1;
            end
            uopAdd:
            begin
                aluOut = aVal + bVal;
                wrEn = 1'b1;
            end
            uopShl:
            begin
                aluOut = aVal << imm[3:0];
                wrEn = 1'b1;
            end
            uopInc:
            begin
                aluOut = aVal + 1'b1;
                wrEn = 1'b1;
            end
            uopDec:
            begin
                aluOut = aVal - 1'b1;
                wrEn = 1'b1;
            end
            uopLatch:
            begin
                aluOut = AddrW'(aVal[7:0]);
                wrEn = 1'b1;
            end
            default:
            begin
                aluOut = '0;
                wrEn = 1'b0;
            end
        endcase
        // Results only retire while running
        if (state != seqRun)
            wrEn = 1'b0;
    end

    // The map is 32 tiles wide, so the column wraps
    assign wrData = (uop.dst == regCol) ? AddrW'(aluOut[4:0]) : aluOut;

    //////////////////////////////////////////////////////////////////////
    // Scratch registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock)
    begin
        if (state == seqIdle && start)
        begin
            regFile[regTmp] <= AddrW'(line[7:3]);
            regFile[regLineRow] <= AddrW'(line[2:0]);
            regFile[regData] <= AddrW'(scrollTile);
            regFile[regMapRow] <= `BGF_MAP_BASE;
            regFile[regTileBase] <= `BGF_TILE_BASE;
        end
        else if (state == seqWait && uop.op == uopReadVram && wbAck)
            regFile[regData] <= AddrW'(wbDat);
        else if (wrEn && uop.dst != regNull)
            regFile[uop.dst] <= wrData;
    end

    //////////////////////////////////////////////////////////////////////
    // Micro-program control and Wishbone master
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state <= seqIdle;
            uPc <= '0;
            wbReq.cyc <= 1'b0;
            wbReq.stb <= 1'b0;
            done <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                seqIdle:
                begin
                    // A start while busy never reaches this branch
                    if (start)
                    begin
                        uPc <= '0;
                        state <= seqRun;
                    end
                end
                seqRun:
                begin
                    case (uop.op)
                        uopReadVram:
                        begin
                            // Cycle and strobe rise together with a fixed address
                            wbReq.cyc <= 1'b1;
                            wbReq.stb <= 1'b1;
                            wbReq.adr <= regFile[regAddr];
                            state <= seqWait;
                        end
                        uopPushBlock:
                        begin
                            if (full)
                                state <= seqWait;
                            else
                                uPc <= uPc + 1'b1;
                        end
                        uopJumpNotZero:
                            uPc <= (aVal != '0) ? imm[4:0] : uPc + 1'b1;
                        uopEnd:
                        begin
                            state <= seqIdle;
                            done <= 1'b1;
                        end
                        default:
                            uPc <= uPc + 1'b1;
                    endcase
                end
                seqWait:
                begin
                    if (uop.op == uopReadVram)
                    begin
                        // Data is taken with ack, the bus drops the cycle after
                        if (wbAck)
                        begin
                            wbReq.cyc <= 1'b0;
                            wbReq.stb <= 1'b0;
                            uPc <= uPc + 1'b1;
                            state <= seqRun;
                        end
                    end
                    else if (!full)
                    begin
                        uPc <= uPc + 1'b1;
                        state <= seqRun;
                    end
                end
                default:
                    state <= seqIdle;
            endcase
        end
    end

    // Push goes out in the same cycle the FIFO shows room
    assign push = (state != seqIdle) && (uop.op == uopPushBlock) && !full;
    assign block.lo = regFile[regLo][7:0];
    assign block.hi = regFile[regHi][7:0];
    assign busy = (state != seqIdle);

endmodule

//--- verilog/bgfetchTop.sv
`timescale 1ns/10ps

module bgfetchTop
(
    input  logic                clock,
    input  logic                reset,
    input  logic                start,
    input  logic [7:0]          line,
    input  logic [4:0]          scrollTile,
    output bgfetch_pkg::wbReq_t wbReq,
    input  logic [7:0]          wbDat,
    input  logic                wbAck,
    output logic [1:0]          pixel,
    output logic                pixelValid,
    input  logic                pixelReady,
    output logic                busy,
    output logic                done
);
    import bgfetch_pkg::*;

    // Sequencer to FIFO
    logic      push;
    pixBlock_t block;
    logic      full;

    // FIFO to serializer
    pixBlock_t headBlock;
    logic      empty;
    logic      pop;

    bgfetchSequencer sequencer
    (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .line       (line),
        .scrollTile (scrollTile),
        .wbReq      (wbReq),
        .wbDat      (wbDat),
        .wbAck      (wbAck),
        .push       (push),
        .block      (block),
        .full       (full),
        .busy       (busy),
        .done       (done)
    );

    tileRowFifo fifo
    (
        .clock     (clock),
        .reset     (reset),
        .push      (push),
        .pushBlock (block),
        .pop       (pop),
        .headBlock (headBlock),
        .full      (full),
        .empty     (empty)
    );

    pixelSerializer serializer
    (
        .clock      (clock),
        .reset      (reset),
        .headBlock  (headBlock),
        .empty      (empty),
        .pop        (pop),
        .pixel      (pixel),
        .pixelValid (pixelValid),
        .pixelReady (pixelReady)
    );

endmodule

//--- verilog/bgfetchUcodeRom.sv
`timescale 1ns/10ps
`include "bgfetch_params.svh"

module bgfetchUcodeRom
(
    input  logic [4:0]          uPc,
    output bgfetch_pkg::ucode_t uop
);
    import bgfetch_pkg::*;

    // Entry of the per-tile loop
    localparam logic [7:0] LoopStart = 8'd6;

    // Word with a register as the third operand
    function automatic ucode_t regOp(uop_t op, regSel_t dst, regSel_t srcA, regSel_t srcB);
        ucode_t word;
        word.op = op;
        word.dst = dst;
        word.srcA = srcA;
        word.arg.b.pad = '0;
        word.arg.b.srcB = srcB;
        return word;
    endfunction

    // Word with an 8-bit immediate as the third operand
    function automatic ucode_t immOp(uop_t op, regSel_t dst, regSel_t srcA, logic [7:0] imm);
        ucode_t word;
        word.op = op;
        word.dst = dst;
        word.srcA = srcA;
        word.arg.i.pad = '0;
        word.arg.i.imm = imm;
        return word;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Fetch program
    //////////////////////////////////////////////////////////////////////

    // On entry tmp holds line/8, lineRow holds line mod 8, data holds the
    // coarse scroll, mapRow and tileBase hold the VRAM base addresses
    always_comb
    begin
        case (uPc)
            5'd0 : uop = regOp(uopNop, regNull, regNull, regNull);
            // Map row base is mapBase + (line/8)*32
            5'd1 : uop = immOp(uopShl, regTmp, regTmp, 8'd5);
            5'd2 : uop = regOp(uopAdd, regMapRow, regMapRow, regTmp);
            // Each tile row is two bytes
            5'd3 : uop = immOp(uopShl, regLineRow, regLineRow, 8'd1);
            5'd4 : uop = immOp(uopLoadImm, regCount, regNull, 8'(`BGF_TILES_PER_LINE));
            5'd5 : uop = regOp(uopAdd, regCol, regData, regNull);
            // Tile index from the map
            5'd6 : uop = regOp(uopAdd, regAddr, regMapRow, regCol);
            5'd7 : uop = regOp(uopReadVram, regData, regNull, regNull);
            // Tile row address is tileBase + index*16 + lineRow*2
            5'd8 : uop = immOp(uopShl, regTmp, regData, 8'd4);
            5'd9 : uop = regOp(uopAdd, regTmp, regTmp, regLineRow);
            5'd10: uop = regOp(uopAdd, regAddr, regTmp, regTileBase);
            // Low plane first, high plane at the next byte
            5'd11: uop = regOp(uopReadVram, regData, regNull, regNull);
            5'd12: uop = regOp(uopLatch, regLo, regData, regNull);
            5'd13: uop = regOp(uopInc, regAddr, regAddr, regNull);
            5'd14: uop = regOp(uopReadVram, regData, regNull, regNull);
            5'd15: uop = regOp(uopLatch, regHi, regData, regNull);
            5'd16: uop = regOp(uopPushBlock, regNull, regNull, regNull);
            // Next map column, the write back wraps it at 32
            5'd17: uop = regOp(uopInc, regCol, regCol, regNull);
            5'd18: uop = regOp(uopDec, regCount, regCount, regNull);
            5'd19: uop = immOp(uopJumpNotZero, regNull, regCount, LoopStart);
            5'd20: uop = regOp(uopEnd, regNull, regNull, regNull);
            // Unused slots stop the sequencer
            default: uop = regOp(uopEnd, regNull, regNull, regNull);
        endcase
    end

endmodule

//--- verilog/bgfetch_params.svh
`ifndef BGFETCH_PARAMS_SVH
`define BGFETCH_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// VRAM layout seen by the background fetch unit
//////////////////////////////////////////////////////////////////////

// Byte address width of the VRAM port, 8 KB of video memory
`define BGF_ADDR_W 13

// Start of the 32x32 background tile map
`define BGF_MAP_BASE 13'h1800

// Start of the tile data, tiles are 16 bytes each and always unsigned
`define BGF_TILE_BASE 13'h0000

//////////////////////////////////////////////////////////////////////
// Line and buffering geometry
//////////////////////////////////////////////////////////////////////

// Visible tiles on one scanline, 160 pixels
`define BGF_TILES_PER_LINE 20

// Number of 8-pixel blocks held between fetch and serializer
`define BGF_FIFO_DEPTH 4

`endif

//--- verilog/bgfetch_pkg.sv
`include "bgfetch_params.svh"

package bgfetch_pkg;

    // Micro-operations understood by the fetch sequencer
    typedef enum logic [3:0]
    {
        uopNop, uopLoadImm, uopAdd, uopShl, uopInc, uopDec, uopReadVram,
        uopLatch, uopPushBlock, uopJumpNotZero, uopEnd
    } uop_t;

    // Scratch register selects, regNull reads as zero and discards writes
    typedef enum logic [3:0]
    {
        regNull, regCount, regCol, regAddr, regTmp, regData, regLo, regHi,
        regLineRow, regMapRow, regTileBase
    } regSel_t;

    // Third operand slot holds either a register select or an immediate
    typedef union packed
    {
        struct packed
        {
            logic [7:0] pad;
            regSel_t    srcB;
        } b;
        struct packed
        {
            logic [3:0] pad;
            logic [7:0] imm;
        } i;
    } ucodeArg_t;

    // One 24-bit microinstruction word
    typedef struct packed
    {
        uop_t      op;
        regSel_t   dst;
        regSel_t   srcA;
        ucodeArg_t arg;
    } ucode_t;

    // Wishbone classic read request, we is tied low by the master
    typedef struct packed
    {
        logic                   cyc;
        logic                   stb;
        logic [`BGF_ADDR_W-1:0] adr;
    } wbReq_t;

    // Both bit planes of one 8-pixel tile row
    typedef struct packed
    {
        logic [7:0] hi;
        logic [7:0] lo;
    } pixBlock_t;

endpackage

//--- verilog/pixelSerializer.sv
`timescale 1ns/10ps

module pixelSerializer
(
    input  logic                   clock,
    input  logic                   reset,
    input  bgfetch_pkg::pixBlock_t headBlock,
    input  logic                   empty,
    output logic                   pop,
    output logic [1:0]             pixel,
    output logic                   pixelValid,
    input  logic                   pixelReady
);

    logic [7:0] hiShift;
    logic [7:0] loShift;
    logic [2:0] bitCount;
    logic       load;
    logic       xfer;

    // A new block is copied only when the previous one is fully sent
    assign load = !pixelValid && !empty;
    assign xfer = pixelValid && pixelReady;

    // The FIFO entry is released with the eighth pixel
    assign pop = xfer && (bitCount == 3'd7);

    // Leftmost pixel sits in bit 7 of both planes
    assign pixel = {hiShift[7], loShift[7]};

    //////////////////////////////////////////////////////////////////////
    // Handshake control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            pixelValid <= 1'b0;
            bitCount <= '0;
        end
        else if (load)
        begin
            pixelValid <= 1'b1;
            bitCount <= '0;
        end
        else if (xfer)
        begin
            bitCount <= bitCount + 1'b1;
            if (bitCount == 3'd7)
                pixelValid <= 1'b0;
        end
    end

    // Plane shifters hold still while the consumer stalls
    always_ff @(posedge clock)
    begin
        if (load)
        begin
            hiShift <= headBlock.hi;
            loShift <= headBlock.lo;
        end
        else if (xfer)
        begin
            hiShift <= {hiShift[6:0], 1'b0};
            loShift <= {loShift[6:0], 1'b0};
        end
    end

endmodule

//--- verilog/tileRowFifo.sv
`timescale 1ns/10ps
`include "bgfetch_params.svh"

module tileRowFifo
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   push,
    input  bgfetch_pkg::pixBlock_t pushBlock,
    input  logic                   pop,
    output bgfetch_pkg::pixBlock_t headBlock,
    output logic                   full,
    output logic                   empty
);
    import bgfetch_pkg::*;

    localparam int Depth = `BGF_FIFO_DEPTH;
    localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW = $clog2(Depth + 1);

    pixBlock_t       mem [Depth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;
    logic            doPush;
    logic            doPop;

    // Pointer step with a wrap that also works for odd depths
    function automatic logic [PtrW-1:0] nextPtr(logic [PtrW-1:0] ptr);
        return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Overflow and underflow requests are dropped here
    assign doPush = push && !full;
    assign doPop = pop && !empty;

    always_ff @(posedge clock)
    begin
        if (doPush)
            mem[wrPtr] <= pushBlock;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (doPush)
                wrPtr <= nextPtr(wrPtr);
            if (doPop)
                rdPtr <= nextPtr(rdPtr);
            // Simultaneous push and pop leave the occupancy alone
            if (doPush && !doPop)
                count <= count + 1'b1;
            else if (doPop && !doPush)
                count <= count - 1'b1;
        end
    end

    assign headBlock = mem[rdPtr];
    assign full = (count == CntW'(Depth));
    assign empty = (count == '0);

endmodule
